//--- exec_pkg.sv
package exec_pkg;

  // Width shared by the ALU and load/store operation codes.
  localparam int op_width = 4;

  // ----------------------------------------------------------
  // Operation codes
  // ----------------------------------------------------------

  typedef enum logic [op_width-1:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_t;

  // Same values as the funct3 field of the branch opcode.
  typedef enum logic [2:0] {
    bcu_beq  = 3'b000,
    bcu_bne  = 3'b001,
    bcu_blt  = 3'b100,
    bcu_bge  = 3'b101,
    bcu_bltu = 3'b110,
    bcu_bgeu = 3'b111
  } bcu_op_t;

  // Bit 3 marks a store and the low bits hold funct3.
  typedef enum logic [op_width-1:0] {
    lsu_lb  = 4'b0000,
    lsu_lh  = 4'b0001,
    lsu_lw  = 4'b0010,
    lsu_lbu = 4'b0100,
    lsu_lhu = 4'b0101,
    lsu_sb  = 4'b1000,
    lsu_sh  = 4'b1001,
    lsu_sw  = 4'b1010
  } lsu_op_t;

  typedef enum logic [1:0] {
    div_div  = 2'd0,
    div_divu = 2'd1,
    div_rem  = 2'd2,
    div_remu = 2'd3
  } div_op_t;

  // ----------------------------------------------------------
  // Exception causes
  // ----------------------------------------------------------

  localparam logic [3:0] cause_inst_misaligned  = 4'd0;
  localparam logic [3:0] cause_load_misaligned  = 4'd4;
  localparam logic [3:0] cause_store_misaligned = 4'd6;

endpackage

//--- alu.sv
`timescale 1ns/10ps

module alu
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  alu_op_t         op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [XLEN-1:0] imm,
  input  logic            sel_imm,
  output logic [XLEN-1:0] result
);

  localparam int shift_w = $clog2(XLEN);

  logic [XLEN-1:0]    opb;
  logic [shift_w-1:0] shamt;

  assign opb   = sel_imm ? imm : b;
  assign shamt = opb[shift_w-1:0];  // Low bits only.

  always_comb begin
    case (op)
      alu_add:  result = a + opb;
      alu_sub:  result = a - opb;
      alu_sll:  result = a << shamt;
      alu_slt:  result = XLEN'($signed(a) < $signed(opb));
      alu_sltu: result = XLEN'(a < opb);
      alu_xor:  result = a ^ opb;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $unsigned($signed(a) >>> shamt);
      alu_or:   result = a | opb;
      alu_and:  result = a & opb;
      default:  result = '0;
    endcase
  end

endmodule

//--- branch_unit.sv
`timescale 1ns/10ps

module branch_unit
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  bcu_op_t         op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic            taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    case (op)
      bcu_beq:  taken = eq;
      bcu_bne:  taken = ~eq;
      bcu_blt:  taken = lt;
      bcu_bge:  taken = ~lt;
      bcu_bltu: taken = ltu;
      bcu_bgeu: taken = ~ltu;
      default:  taken = 1'b0;
    endcase
  end

endmodule

//--- agu.sv
`timescale 1ns/10ps

module agu
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]   rdata1,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   pc,
  input  logic              jal, jalr, branch, load, store,
  input  lsu_op_t           lsu_op,
  output logic [XLEN-1:0]   address,
  output logic [XLEN/8-1:0] byteenable,
  output logic              exception,
  output logic [3:0]        ecause
);

  localparam int nbytes = XLEN / 8;
  localparam int lane_w = $clog2(nbytes);

  logic [XLEN-1:0]   base;
  logic [XLEN-1:0]   sum;
  logic [nbytes-1:0] mask;
  logic              half;
  logic              word;
  logic              access_bad;
  logic              target_bad;

  assign base    = (jalr | load | store) ? rdata1 : pc;  // Else pc for jal, branch, auipc.
  assign sum     = base + imm;
  assign address = jalr ? {sum[XLEN-1:1], 1'b0} : sum;

  always_comb begin
    half = 1'b0;
    word = 1'b0;
    case (lsu_op)
      lsu_lh, lsu_lhu, lsu_sh: begin
        mask = nbytes'(4'h3);
        half = 1'b1;
      end
      lsu_lw, lsu_sw: begin
        mask = nbytes'(4'hf);
        word = 1'b1;
      end
      default: mask = nbytes'(4'h1);
    endcase
  end

  assign byteenable = (load | store) ? (mask << address[lane_w-1:0]) : '0;

  assign access_bad = (half & address[0]) | (word & |address[1:0]);
  assign target_bad = (jal | jalr | branch) & |address[1:0];
  assign exception  = (load | store) ? access_bad : target_bad;
  assign ecause     = load  ? cause_load_misaligned :
                      store ? cause_store_misaligned : cause_inst_misaligned;

endmodule

//--- divider.sv
`timescale 1ns/10ps

module divider
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            enable,
  input  div_op_t         op,
  input  logic [XLEN-1:0] dividend,
  input  logic [XLEN-1:0] divisor,
  output logic            ready,
  output logic [XLEN-1:0] result
);

  localparam int cnt_w = $clog2(XLEN);

  logic             busy;
  logic             done;
  logic             start;
  logic             is_signed;
  logic             neg_a;
  logic             neg_b;
  logic [XLEN-1:0]  abs_a;
  logic [XLEN-1:0]  abs_b;
  logic [cnt_w-1:0] count;
  logic [XLEN-1:0]  quo;
  logic [XLEN-1:0]  rem;
  logic [XLEN-1:0]  dvs;
  logic             neg_q;
  logic             neg_r;
  logic             want_rem;
  logic [XLEN:0]    shifted;
  logic             ge;
  logic [XLEN-1:0]  diff;

  assign start     = enable & ~busy & ~done;
  assign is_signed = (op == div_div) | (op == div_rem);
  assign neg_a     = is_signed & dividend[XLEN-1];
  assign neg_b     = is_signed & divisor[XLEN-1];
  assign abs_a     = neg_a ? -dividend : dividend;
  assign abs_b     = neg_b ? -divisor : divisor;

  // ----------------------------------------------------------
  // One restoring step per cycle
  // ----------------------------------------------------------

  assign shifted = {rem, quo[XLEN-1]};
  assign ge      = (shifted >= {1'b0, dvs});
  assign diff    = shifted[XLEN-1:0] - dvs;

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= busy & enable & (count == '0);  // Ready for a single cycle.
      if (start) begin
        busy <= 1'b1;
      end else if (~enable | (count == '0)) begin
        busy <= 1'b0;  // Finished or aborted.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo      <= abs_a;
      rem      <= '0;
      dvs      <= abs_b;
      count    <= cnt_w'(XLEN - 1);
      neg_q    <= (neg_a ^ neg_b) & (|divisor);  // Zero divisor keeps all ones.
      neg_r    <= neg_a;
      want_rem <= (op == div_rem) | (op == div_remu);
    end else if (busy) begin
      quo   <= {quo[XLEN-2:0], ge};
      rem   <= ge ? diff : shifted[XLEN-1:0];
      count <= count - 1'b1;
    end
  end

  // Overflow case falls out of the unsigned magnitudes.
  assign ready  = done;
  assign result = want_rem ? (neg_r ? -rem : rem) : (neg_q ? -quo : quo);

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps

module execute_stage
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  logic [XLEN-1:0]   pc,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   rdata1,
  input  logic [XLEN-1:0]   rdata2,
  input  logic [4:0]        waddr,
  input  logic              sel_imm,
  input  alu_op_t           alu_op,
  input  bcu_op_t           bcu_op,
  input  lsu_op_t           lsu_op,
  input  div_op_t           div_op,
  input  logic              lui, auipc, jal, jalr,
  input  logic              branch, load, store, division,
  input  logic              mem_stall,
  input  logic              flush,
  output logic              stall,
  output logic [XLEN-1:0]   alu_a,
  output logic [XLEN-1:0]   alu_b,
  output logic [XLEN-1:0]   alu_imm,
  output logic              alu_sel_imm,
  output alu_op_t           alu_op_out,
  input  logic [XLEN-1:0]   alu_result,
  output logic [XLEN-1:0]   bcu_a,
  output logic [XLEN-1:0]   bcu_b,
  output bcu_op_t           bcu_op_out,
  input  logic              bcu_taken,
  output logic [XLEN-1:0]   agu_rdata1,
  output logic [XLEN-1:0]   agu_imm,
  output logic [XLEN-1:0]   agu_pc,
  output logic              agu_jal, agu_jalr, agu_branch, agu_load, agu_store,
  output lsu_op_t           agu_lsu_op,
  input  logic [XLEN-1:0]   agu_address,
  input  logic [XLEN/8-1:0] agu_byteenable,
  input  logic              agu_exception,
  input  logic [3:0]        agu_ecause,
  output logic              div_enable,
  output logic [XLEN-1:0]   dividend,
  output logic [XLEN-1:0]   divisor,
  output div_op_t           div_op_out,
  input  logic              div_ready,
  input  logic [XLEN-1:0]   div_result,
  output logic              q_valid, q_wren, q_load, q_store, q_jump, q_exception,
  output logic [4:0]        q_waddr,
  output logic [XLEN-1:0]   q_wdata,
  output lsu_op_t           q_lsu_op,
  output logic [XLEN-1:0]   q_address,
  output logic [XLEN/8-1:0] q_byteenable,
  output logic [XLEN-1:0]   q_sdata,
  output logic [3:0]        q_ecause,
  output logic [XLEN-1:0]   q_etval
);

  logic            squash;
  logic            div_wait;
  logic            accept;
  logic            jump;
  logic            exc;
  logic [XLEN-1:0] wdata;

  // ----------------------------------------------------------
  // Functional unit operands
  // ----------------------------------------------------------

  assign alu_a       = rdata1;
  assign alu_b       = rdata2;
  assign alu_imm     = imm;
  assign alu_sel_imm = sel_imm;
  assign alu_op_out  = alu_op;
  assign bcu_a       = rdata1;
  assign bcu_b       = rdata2;
  assign bcu_op_out  = bcu_op;
  assign agu_rdata1  = rdata1;
  assign agu_imm     = imm;
  assign agu_pc      = pc;
  assign agu_jal     = jal;
  assign agu_jalr    = jalr;
  assign agu_branch  = branch;
  assign agu_load    = load;
  assign agu_store   = store;
  assign agu_lsu_op  = lsu_op;
  assign dividend    = rdata1;
  assign divisor     = rdata2;
  assign div_op_out  = div_op;

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------

  assign squash     = flush | q_jump;  // Wrong-path instruction.
  assign div_enable = valid & division & ~squash;
  assign div_wait   = div_enable & ~div_ready;
  assign stall      = div_wait | mem_stall;
  assign accept     = valid & ~squash & ~div_wait;
  assign jump       = jal | jalr | (branch & bcu_taken);
  assign exc        = agu_exception & (load | store | jump);  // Untaken branch never traps.

  always_comb begin
    if (auipc) begin
      wdata = agu_address;  // pc + imm.
    end else if (lui) begin
      wdata = imm;
    end else if (jal | jalr) begin
      wdata = pc + XLEN'(4);
    end else if (division) begin
      wdata = div_result;
    end else begin
      wdata = alu_result;
    end
  end

  // ----------------------------------------------------------
  // Execute/memory register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      q_valid     <= 1'b0;
      q_wren      <= 1'b0;
      q_load      <= 1'b0;
      q_store     <= 1'b0;
      q_jump      <= 1'b0;
      q_exception <= 1'b0;
    end else if (mem_stall == 1'b0) begin
      q_valid     <= accept;
      q_wren      <= accept & ~store & ~branch & (|waddr) & ~exc;
      q_load      <= accept & load & ~exc;
      q_store     <= accept & store & ~exc;
      q_jump      <= accept & jump & ~exc;
      q_exception <= accept & exc;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_stall == 1'b0) begin
      q_waddr      <= waddr;
      q_wdata      <= wdata;
      q_lsu_op     <= lsu_op;
      q_address    <= agu_address;
      q_byteenable <= agu_byteenable;
      q_sdata      <= rdata2;
      q_ecause     <= agu_ecause;
      q_etval      <= agu_address;
    end
  end

endmodule

//--- execute_top.sv
`timescale 1ns/10ps

module execute_top
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  logic [XLEN-1:0]   pc,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   rdata1,
  input  logic [XLEN-1:0]   rdata2,
  input  logic [4:0]        waddr,
  input  logic              sel_imm,
  input  alu_op_t           alu_op,
  input  bcu_op_t           bcu_op,
  input  lsu_op_t           lsu_op,
  input  div_op_t           div_op,
  input  logic              lui, auipc, jal, jalr,
  input  logic              branch, load, store, division,
  input  logic              mem_stall,
  input  logic              flush,
  output logic              stall,
  output logic              q_valid, q_wren, q_load, q_store, q_jump, q_exception,
  output logic [4:0]        q_waddr,
  output logic [XLEN-1:0]   q_wdata,
  output lsu_op_t           q_lsu_op,
  output logic [XLEN-1:0]   q_address,
  output logic [XLEN/8-1:0] q_byteenable,
  output logic [XLEN-1:0]   q_sdata,
  output logic [3:0]        q_ecause,
  output logic [XLEN-1:0]   q_etval
);

  // ----------------------------------------------------------
  // Stage to unit wiring
  // ----------------------------------------------------------

  logic [XLEN-1:0]   alu_a;
  logic [XLEN-1:0]   alu_b;
  logic [XLEN-1:0]   alu_imm;
  logic              alu_sel_imm;
  alu_op_t           alu_op_out;
  logic [XLEN-1:0]   alu_result;
  logic [XLEN-1:0]   bcu_a;
  logic [XLEN-1:0]   bcu_b;
  bcu_op_t           bcu_op_out;
  logic              bcu_taken;
  logic [XLEN-1:0]   agu_rdata1;
  logic [XLEN-1:0]   agu_imm;
  logic [XLEN-1:0]   agu_pc;
  logic              agu_jal, agu_jalr, agu_branch, agu_load, agu_store;
  lsu_op_t           agu_lsu_op;
  logic [XLEN-1:0]   agu_address;
  logic [XLEN/8-1:0] agu_byteenable;
  logic              agu_exception;
  logic [3:0]        agu_ecause;
  logic              div_enable;
  logic [XLEN-1:0]   dividend;
  logic [XLEN-1:0]   divisor;
  div_op_t           div_op_out;
  logic              div_ready;
  logic [XLEN-1:0]   div_result;

  execute_stage #(.XLEN(XLEN)) u_stage (.*);  // Port names match one to one.

  alu #(.XLEN(XLEN)) u_alu (
    .op      (alu_op_out),
    .a       (alu_a),
    .b       (alu_b),
    .imm     (alu_imm),
    .sel_imm (alu_sel_imm),
    .result  (alu_result)
  );

  branch_unit #(.XLEN(XLEN)) u_bcu (
    .op    (bcu_op_out),
    .a     (bcu_a),
    .b     (bcu_b),
    .taken (bcu_taken)
  );

  agu #(.XLEN(XLEN)) u_agu (
    .rdata1     (agu_rdata1),
    .imm        (agu_imm),
    .pc         (agu_pc),
    .jal        (agu_jal),
    .jalr       (agu_jalr),
    .branch     (agu_branch),
    .load       (agu_load),
    .store      (agu_store),
    .lsu_op     (agu_lsu_op),
    .address    (agu_address),
    .byteenable (agu_byteenable),
    .exception  (agu_exception),
    .ecause     (agu_ecause)
  );

  divider #(.XLEN(XLEN)) u_div (
    .clk      (clk),
    .rst      (rst),
    .enable   (div_enable),
    .op       (div_op_out),
    .dividend (dividend),
    .divisor  (divisor),
    .ready    (div_ready),
    .result   (div_result)
  );

endmodule

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference results. Included inside the testbench module, after XLEN and the package import.

function automatic logic [XLEN-1:0] model_alu(alu_op_t op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
  int unsigned sh;
  sh = int'(b[$clog2(XLEN)-1:0]);
  case (op)
    alu_add:  return a + b;
    alu_sub:  return a - b;
    alu_sll:  return a << sh;
    alu_slt:  return XLEN'($signed(a) < $signed(b));
    alu_sltu: return XLEN'(a < b);
    alu_xor:  return a ^ b;
    alu_srl:  return a >> sh;
    alu_sra:  return $unsigned($signed(a) >>> sh);
    alu_or:   return a | b;
    alu_and:  return a & b;
    default:  return '0;
  endcase
endfunction

function automatic logic model_taken(bcu_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  case (op)
    bcu_beq:  return a == b;
    bcu_bne:  return a != b;
    bcu_blt:  return $signed(a) < $signed(b);
    bcu_bge:  return $signed(a) >= $signed(b);
    bcu_bltu: return a < b;
    bcu_bgeu: return a >= b;
    default:  return 1'b0;
  endcase
endfunction

// Memory accesses and jalr use rdata1 as base and the rest use pc.
function automatic logic [XLEN-1:0] model_address(logic jalr, logic mem, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] pc, logic [XLEN-1:0] imm);
  logic [XLEN-1:0] s;
  s = ((jalr | mem) ? a : pc) + imm;
  return jalr ? (s & ~XLEN'(1)) : s;
endfunction

function automatic logic [XLEN/8-1:0] model_byteenable(lsu_op_t op, logic [XLEN-1:0] addr);
  logic [XLEN/8-1:0] m;
  case (op)
    lsu_lh, lsu_lhu, lsu_sh: m = (XLEN/8)'(4'h3);
    lsu_lw, lsu_sw:          m = (XLEN/8)'(4'hf);
    default:                 m = (XLEN/8)'(4'h1);
  endcase
  return m << addr[$clog2(XLEN/8)-1:0];
endfunction

function automatic logic model_misaligned(lsu_op_t op, logic [XLEN-1:0] addr);
  case (op)
    lsu_lh, lsu_lhu, lsu_sh: return addr[0];
    lsu_lw, lsu_sw:          return |addr[1:0];
    default:                 return 1'b0;
  endcase
endfunction

function automatic logic [XLEN-1:0] model_div(div_op_t op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
  logic ovf;
  ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
  if (b == '0) return (op == div_div || op == div_divu) ? '1 : a;
  case (op)
    div_div:  return ovf ? a : $unsigned($signed(a) / $signed(b));
    div_rem:  return ovf ? '0 : $unsigned($signed(a) % $signed(b));
    div_divu: return a / b;
    default:  return a % b;
  endcase
endfunction

`endif

//--- tb_execute.sv
`timescale 1ns/10ps

module tb_execute
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) ();

  `include "tb_model.svh"

  localparam int     n_tests  = 420;  // Instructions over all sections.
  localparam longint limit_ns = longint'(n_tests) * (XLEN + 4) * 40 + 100 * 40;

  logic              clk = 1'b0;
  logic              rst;
  logic              valid, sel_imm, lui, auipc, jal, jalr, branch, load, store, division;
  logic [XLEN-1:0]   pc, imm, rdata1, rdata2;
  logic [4:0]        waddr;
  alu_op_t           alu_op;
  bcu_op_t           bcu_op;
  lsu_op_t           lsu_op;
  div_op_t           div_op;
  logic              mem_stall, flush, stall;
  logic              q_valid, q_wren, q_load, q_store, q_jump, q_exception;
  logic [4:0]        q_waddr;
  logic [XLEN-1:0]   q_wdata, q_address, q_sdata, q_etval;
  logic [XLEN/8-1:0] q_byteenable;
  lsu_op_t           q_lsu_op;
  logic [3:0]        q_ecause;

  int      seed = 32'hb25e_5213;
  logic    prev_jump;  // Expected q_jump of the last loaded instruction.
  bcu_op_t bcu_ops [6] = '{bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu};
  lsu_op_t lsu_ops [8] = '{lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw};

  execute_top #(.XLEN(XLEN)) UUT (.*);

  always #20 clk = ~clk;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] exp,
                       input logic [XLEN-1:0] act);
    assert (act === exp)
      else fail_now($sformatf("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  function automatic logic [XLEN-1:0] rand_word();
    return XLEN'({$random(seed), $random(seed)});
  endfunction

  // Random instruction with no class flag set.
  task automatic new_instr();
    valid    = 1'b1;
    pc       = rand_word() & ~XLEN'(3);
    imm      = rand_word();
    rdata1   = rand_word();
    rdata2   = rand_word();
    waddr    = 5'($random(seed));
    sel_imm  = 1'($random(seed));
    alu_op   = alu_op_t'(4'($unsigned($random(seed)) % 10));
    bcu_op   = bcu_ops[$unsigned($random(seed)) % 6];
    lsu_op   = lsu_ops[$unsigned($random(seed)) % 8];
    div_op   = div_op_t'(2'($random(seed)));
    lui      = 1'b0;
    auipc    = 1'b0;
    jal      = 1'b0;
    jalr     = 1'b0;
    branch   = 1'b0;
    load     = 1'b0;
    store    = 1'b0;
    division = 1'b0;
  endtask

  task automatic check_result();
    logic            squashed;
    logic            mem;
    logic            jump;
    logic            exc;
    logic            wren;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    squashed = !valid || flush || prev_jump;
    mem      = load || store;
    jump     = jal || jalr || (branch && model_taken(bcu_op, rdata1, rdata2));
    addr     = model_address(jalr, mem, rdata1, pc, imm);
    exc      = mem ? model_misaligned(lsu_op, addr) : (jump && addr[1:0] != 2'b00);
    wren     = !squashed && !store && !branch && waddr != 5'd0 && !exc;
    if (auipc) wdata = pc + imm;
    else if (lui) wdata = imm;
    else if (jal || jalr) wdata = pc + XLEN'(4);
    else if (division) wdata = model_div(div_op, rdata1, rdata2);
    else wdata = model_alu(alu_op, rdata1, sel_imm ? imm : rdata2);
    check("q_valid", !squashed, q_valid);
    check("q_wren", wren, q_wren);
    check("q_load", !squashed && load && !exc, q_load);
    check("q_store", !squashed && store && !exc, q_store);
    check("q_jump", !squashed && jump && !exc, q_jump);
    check("q_exception", !squashed && exc, q_exception);
    if (wren) begin
      check("q_waddr", waddr, q_waddr);
      check("q_wdata", wdata, q_wdata);
    end
    if (!squashed && (mem || jump)) check("q_address", addr, q_address);
    if (!squashed && mem) begin
      check("q_byteenable", model_byteenable(lsu_op, addr), q_byteenable);
      check("q_lsu_op", lsu_op, q_lsu_op);
    end
    if (!squashed && store && !exc) check("q_sdata", rdata2, q_sdata);
    if (!squashed && exc) begin
      check("q_ecause", load ? cause_load_misaligned :
                        (store ? cause_store_misaligned : cause_inst_misaligned), q_ecause);
      check("q_etval", addr, q_etval);
    end
    prev_jump = !squashed && jump && !exc;
  endtask

  // Starts and ends 2 ns after a rising edge.
  task automatic run_instr(input int hold);
    logic            held_valid;
    logic [XLEN-1:0] held_wdata;
    logic [XLEN-1:0] held_addr;
    if (hold > 0) begin
      mem_stall  = 1'b1;
      held_valid = q_valid;
      held_wdata = q_wdata;
      held_addr  = q_address;
      repeat (hold) begin
        @(negedge clk);
        check("stall", 1'b1, stall);
        @(posedge clk);
        #1;
        check("q_valid", held_valid, q_valid);
        check("q_wdata", held_wdata, q_wdata);
        check("q_address", held_addr, q_address);
      end
      #1 mem_stall = 1'b0;
    end
    @(negedge clk);
    if (hold == 0 && division && !flush && !prev_jump) check("stall", 1'b1, stall);
    while (stall) begin
      assert (division) else fail_now("stall went high for an instruction that is no division");
      @(negedge clk);
      check("q_valid", 1'b0, q_valid);  // Bubble while the division is pending.
    end
    @(posedge clk);
    #1;
    check_result();
    #1;
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    prev_jump = 1'b0;
    mem_stall = 1'b0;
    flush     = 1'b0;
    rst       = 1'b0;
    new_instr();
    valid = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst = 1'b1;
    check("q_valid", 1'b0, q_valid);
    check("q_wren", 1'b0, q_wren);
    check("q_load", 1'b0, q_load);
    check("q_store", 1'b0, q_store);
    check("q_jump", 1'b0, q_jump);
    check("q_exception", 1'b0, q_exception);
    check("stall", 1'b0, stall);

    repeat (200) begin
      new_instr();
      run_instr(0);
    end

    repeat (60) begin
      new_instr();
      case ($unsigned($random(seed)) % 5)
        0:       lui = 1'b1;
        1:       auipc = 1'b1;
        2:       jal = 1'b1;
        3:       jalr = 1'b1;
        default: branch = 1'b1;
      endcase
      if (($random(seed) & 7) != 0) begin  // Mostly aligned targets.
        imm    = imm & ~XLEN'(3);
        rdata1 = rdata1 & ~XLEN'(3);
      end
      if ($random(seed) & 1) rdata2 = rdata1;
      run_instr(0);
    end

    repeat (60) begin
      new_instr();
      store = lsu_op[3];
      load  = !lsu_op[3];
      run_instr(0);
    end

    for (int i = 0; i < 40; i++) begin
      new_instr();
      division = 1'b1;
      div_op   = div_op_t'(i / 10);
      if (i % 10 == 1) rdata2 = '0;
      if (i % 10 == 2) begin
        rdata1 = {1'b1, {(XLEN-1){1'b0}}};
        rdata2 = '1;
      end
      run_instr(0);
    end

    repeat (60) begin
      new_instr();
      case ($unsigned($random(seed)) % 4)
        0:       division = 1'b1;
        1:       jal = 1'b1;
        2:       load = 1'b1;
        default: sel_imm = 1'b1;
      endcase
      flush = (($random(seed) & 7) == 0);
      run_instr((($random(seed) & 3) == 0) ? 1 + $unsigned($random(seed)) % 4 : 0);
      flush = 1'b0;
    end

    valid = 1'b0;
    @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(limit_ns);
    fail_now("Timeout: the tests did not finish in the expected time");
  end

endmodule

//--- files.f
+incdir+.
exec_pkg.sv
alu.sv
branch_unit.sv
agu.sv
divider.sv
execute_stage.sv
execute_top.sv
tb_execute.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_execute -f files.f -o tb_execute \
  && ./obj_dir/tb_execute > sim.log 2>&1 \
  || echo 'Build or simulation ended with an error' >> sim.log
cat sim.log
grep -q 'Test failures found' sim.log && exit 1 || grep -q 'All tests passed!' sim.log
